//--- Makefile
# Verilator flow for the mmio bridge
VERILATOR ?= verilator
TOP       ?= mmio_tb
RTL_TOP   ?= mmio_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Test OK
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# the log decides, not the exit status of the model
sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^$(PASS_TEXT)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/mem_port.sv
module mem_port import mmio_pkg::*; #(
    parameter int MEM_ADDR_BITS = 10 // word index bits of the memory window
) (
    input  logic   clk,
    input  logic   reset,
    // from controller
    input  logic   mem_start,   // one cycle pulse, host bus stable
    input  logic   mem_we,
    input  addr_t  address,     // host byte address
    input  word_t  wdata,
    // memory bus
    output logic   mem_req,
    output logic   mem_write,
    output addr_t  mem_address,
    output word_t  mem_wdata,
    input  logic   mem_ack,
    input  word_t  mem_rdata,
    // back to controller
    output logic   mem_done,    // one cycle pulse after ack withdrawn
    output word_t  mem_rdata_q
);

    addr_t                    offset;     // byte offset inside the window
    logic [MEM_ADDR_BITS-1:0] word_index;
    logic                     wait_release; // req dropped, ack still high

    assign offset     = address - MEM_BASE;
    assign word_index = offset[MEM_ADDR_BITS+1:2]; // byte lanes ignored

    // handshake sequencing
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_req      <= 1'b0;
            mem_write    <= 1'b0;
            wait_release <= 1'b0;
            mem_done     <= 1'b0;
        end else begin
            mem_done <= 1'b0;
            if (mem_start) begin
                mem_req   <= 1'b1; // rises one cycle after start
                mem_write <= mem_we;
            end else if (mem_req && mem_ack) begin
                mem_req      <= 1'b0;
                wait_release <= 1'b1;
            end else if (wait_release && !mem_ack) begin
                wait_release <= 1'b0;
                mem_done     <= 1'b1;
            end
        end
    end

    // payload, loaded on start
    always_ff @(posedge clk) begin
        if (mem_start) begin
            mem_address <= MEM_BASE + addr_t'({word_index, 2'b00}); // word aligned
            mem_wdata   <= wdata;
        end
        if (mem_req && mem_ack && !mem_write) begin
            mem_rdata_q <= mem_rdata; // valid while ack high
        end
    end

endmodule

//--- hw/mmio_ctrl.sv
module mmio_ctrl import mmio_pkg::*; #(
    parameter int MEM_ADDR_BITS = 10 // word index bits of the memory window
) (
    input  logic   clk,
    input  logic   reset,
    // host side
    input  logic   req,
    input  logic   we,
    input  addr_t  address,
    input  word_t  wdata,
    output logic   ack,
    output word_t  rdata,
    // memory port
    output logic   mem_start,      // one cycle pulse
    output logic   mem_we,
    input  logic   mem_done,
    input  word_t  mem_rdata_q,
    // spi command port
    output logic   spi_param_load, // strobe
    output logic   spi_launch,     // pulse
    input  logic   spi_done,
    // touch latch
    input  word_t  touch_word,
    output logic   touch_clear     // strobe
);

    // window size in bytes
    localparam addr_t MEM_SPAN = addr_t'(1) << (MEM_ADDR_BITS + 2);

    ctrl_state_t state;

    logic in_window;
    logic is_touch;
    logic is_param;
    logic is_cmd;
    logic touch_read; // current access is a touch read

    // address decode, only acted on in idle
    assign in_window = (address >= MEM_BASE) && ((address - MEM_BASE) < MEM_SPAN);
    assign is_touch  = (address == TOUCH_ADDR);
    assign is_param  = (address == SPI_PARAM_ADDR);
    assign is_cmd    = (address == SPI_CMD_ADDR);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state          <= ST_IDLE;
            ack            <= 1'b0;
            rdata          <= '0;
            mem_start      <= 1'b0;
            mem_we         <= 1'b0;
            spi_param_load <= 1'b0;
            spi_launch     <= 1'b0;
            touch_clear    <= 1'b0;
            touch_read     <= 1'b0;
        end else begin
            // pulses default low
            mem_start      <= 1'b0;
            spi_param_load <= 1'b0;
            spi_launch     <= 1'b0;
            touch_clear    <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (req) begin
                        touch_read <= 1'b0;
                        rdata      <= '0; // unmapped and touch writes return zero
                        if (in_window) begin
                            mem_start <= 1'b1;
                            mem_we    <= we;
                            if (we) rdata <= wdata; // write echo
                            state     <= ST_MEM_WAIT;
                        end else if (we && is_param) begin
                            spi_param_load <= 1'b1;
                            rdata          <= wdata;
                            state          <= ST_ACK;
                        end else if (we && is_cmd) begin
                            spi_launch <= 1'b1;
                            rdata      <= wdata;
                            state      <= ST_SPI_WAIT;
                        end else if (!we && is_touch) begin
                            // clear goes out now, word sampled next cycle
                            // so a capture landing on this edge is not lost
                            touch_clear <= 1'b1;
                            touch_read  <= 1'b1;
                            state       <= ST_ACK;
                        end else begin
                            state <= ST_ACK;
                        end
                    end
                end

                ST_MEM_WAIT: begin
                    if (mem_done) begin
                        if (!mem_we) rdata <= mem_rdata_q;
                        ack   <= 1'b1; // rises the cycle after mem_done
                        state <= ST_RELEASE;
                    end
                end

                ST_SPI_WAIT: begin
                    if (spi_done) begin
                        ack   <= 1'b1;
                        state <= ST_RELEASE;
                    end
                end

                ST_ACK: begin
                    if (touch_read) rdata <= touch_word;
                    ack   <= 1'b1;
                    state <= ST_RELEASE;
                end

                ST_RELEASE: begin
                    if (!req) begin // four phase, wait for host to let go
                        ack   <= 1'b0;
                        state <= ST_IDLE;
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- hw/mmio_pkg.sv
package mmio_pkg;

    // data word on every path: host, memory, spi params, touch xy
    typedef logic [31:0] word_t;

    // byte address on host and memory buses
    typedef logic [31:0] addr_t;

    // spi opcode, low byte of the host write
    typedef logic [7:0] spi_cmd_t;

    // register block sits below the memory window
    localparam addr_t TOUCH_ADDR     = 32'h0000_0100; // read only, last xy sample
    localparam addr_t SPI_PARAM_ADDR = 32'h0000_0104; // write only
    localparam addr_t SPI_CMD_ADDR   = 32'h0000_0108; // write only, write launches

    // start of external data memory
    // keep aligned to the window size so word offsets never carry into the base
    localparam addr_t MEM_BASE = 32'h0001_0000;

    // bridge controller states
    typedef enum logic [2:0] {
        ST_IDLE,     // waiting for host req
        ST_MEM_WAIT, // memory cycle in flight
        ST_SPI_WAIT, // command queued behind spi_busy
        ST_ACK,      // one cycle before ack, reg accesses settle here
        ST_RELEASE   // ack high, waiting for req to drop
    } ctrl_state_t;

endpackage

//--- hw/mmio_top.sv
module mmio_top import mmio_pkg::*; #(
    parameter int MEM_ADDR_BITS = 10 // memory window is 4 << MEM_ADDR_BITS bytes
) (
    input  logic     clk,
    input  logic     reset,
    // host
    input  logic     req,
    input  logic     we,
    input  addr_t    address,
    input  word_t    wdata,
    output logic     ack,
    output word_t    rdata,
    // external memory
    output logic     mem_req,
    output logic     mem_write,
    output addr_t    mem_address,
    output word_t    mem_wdata,
    input  logic     mem_ack,
    input  word_t    mem_rdata,
    // spi peripheral
    output word_t    spi_params,
    output spi_cmd_t spi_command,
    output logic     spi_enable,
    input  logic     spi_busy,
    // i2c touch reader
    input  word_t    touch_xy,
    input  logic     touch_done,
    output logic     touch_pending
);

    logic  mem_start;
    logic  mem_we;
    logic  mem_done;
    word_t mem_rdata_q;
    logic  spi_param_load;
    logic  spi_launch;
    logic  spi_done;
    logic  touch_clear;
    word_t touch_word;

    mmio_ctrl #(
        .MEM_ADDR_BITS(MEM_ADDR_BITS)
    ) mmio_ctrl_i (
        .clk            (clk),
        .reset          (reset),
        .req            (req),
        .we             (we),
        .address        (address),
        .wdata          (wdata),
        .ack            (ack),
        .rdata          (rdata),
        .mem_start      (mem_start),
        .mem_we         (mem_we),
        .mem_done       (mem_done),
        .mem_rdata_q    (mem_rdata_q),
        .spi_param_load (spi_param_load),
        .spi_launch     (spi_launch),
        .spi_done       (spi_done),
        .touch_word     (touch_word),
        .touch_clear    (touch_clear)
    );

    mem_port #(
        .MEM_ADDR_BITS(MEM_ADDR_BITS)
    ) mem_port_i (
        .clk         (clk),
        .reset       (reset),
        .mem_start   (mem_start),
        .mem_we      (mem_we),
        .address     (address),   // host holds it until ack
        .wdata       (wdata),
        .mem_req     (mem_req),
        .mem_write   (mem_write),
        .mem_address (mem_address),
        .mem_wdata   (mem_wdata),
        .mem_ack     (mem_ack),
        .mem_rdata   (mem_rdata),
        .mem_done    (mem_done),
        .mem_rdata_q (mem_rdata_q)
    );

    spi_cmd_port spi_cmd_port_i (
        .clk            (clk),
        .reset          (reset),
        .spi_param_load (spi_param_load),
        .spi_launch     (spi_launch),
        .wdata          (wdata),
        .spi_done       (spi_done),
        .spi_params     (spi_params),
        .spi_command    (spi_command),
        .spi_enable     (spi_enable),
        .spi_busy       (spi_busy)
    );

    touch_latch touch_latch_i (
        .clk           (clk),
        .reset         (reset),
        .touch_done    (touch_done),
        .touch_xy      (touch_xy),
        .touch_clear   (touch_clear),
        .touch_word    (touch_word),
        .touch_pending (touch_pending)
    );

endmodule

//--- hw/spi_cmd_port.sv
module spi_cmd_port import mmio_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    // from controller
    input  logic     spi_param_load, // strobe, wdata holds the parameter word
    input  logic     spi_launch,     // pulse, wdata low byte is the opcode
    input  word_t    wdata,
    output logic     spi_done,       // same cycle as spi_enable
    // to peripheral
    output word_t    spi_params,
    output spi_cmd_t spi_command,
    output logic     spi_enable,     // one cycle, only while not busy
    input  logic     spi_busy
);

    logic pending; // command stored, not yet issued

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            spi_params  <= '0;
            spi_command <= '0;
            spi_enable  <= 1'b0;
            spi_done    <= 1'b0;
            pending     <= 1'b0;
        end else begin
            spi_enable <= 1'b0;
            spi_done   <= 1'b0;

            if (spi_param_load) begin
                spi_params <= wdata;
            end

            if (spi_launch) begin
                spi_command <= spi_cmd_t'(wdata[7:0]);
                pending     <= 1'b1;
            end else if (pending && !spi_busy) begin
                // peripheral idle, fire once
                // busy only rises after it sees enable
                spi_enable <= 1'b1;
                spi_done   <= 1'b1;
                pending    <= 1'b0;
            end
        end
    end

endmodule

//--- hw/touch_latch.sv
module touch_latch import mmio_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    // from i2c reader
    input  logic  touch_done,  // one cycle, touch_xy valid with it
    input  word_t touch_xy,
    // from controller
    input  logic  touch_clear, // host has taken the word
    output word_t touch_word,
    output logic  touch_pending
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            touch_word    <= '0;
            touch_pending <= 1'b0;
        end else begin
            if (touch_done) begin
                // new sample beats a clear in the same cycle
                touch_word    <= touch_xy;
                touch_pending <= 1'b1;
            end else if (touch_clear) begin
                touch_pending <= 1'b0;
            end
        end
    end

endmodule

//--- sources.f
hw/mmio_pkg.sv
hw/mmio_ctrl.sv
hw/mem_port.sv
hw/spi_cmd_port.sv
hw/touch_latch.sv
hw/mmio_top.sv
tests/mmio_tb.sv

//--- tests/mmio_tb.sv
module mmio_tb import mmio_pkg::*; ();

    localparam int MEM_ADDR_BITS = 10;
    localparam int MEM_WORDS     = 1 << MEM_ADDR_BITS;
    localparam int TIMEOUT       = 200; // cycles per handshake edge

    logic     clk;
    logic     reset;
    logic     req;
    logic     we;
    addr_t    address;
    word_t    wdata;
    logic     ack;
    word_t    rdata;
    logic     mem_req;
    logic     mem_write;
    addr_t    mem_address;
    word_t    mem_wdata;
    logic     mem_ack = 1'b0;    // driven by memory model
    word_t    mem_rdata = '0;
    word_t    spi_params;
    spi_cmd_t spi_command;
    logic     spi_enable;
    logic     spi_busy = 1'b0;   // driven by spi model
    word_t    touch_xy = '0;     // driven by i2c model
    logic     touch_done = 1'b0;
    logic     touch_pending;

    // one lfsr state per process, all from the same seed
    logic [15:0] main_seed  = 16'd4;
    logic [15:0] mem_seed   = 16'd4;
    logic [15:0] spi_seed   = 16'd4;
    logic [15:0] touch_seed = 16'd4;

    word_t mem_array [0:MEM_WORDS-1]; // external memory contents
    word_t exp_mem   [0:MEM_WORDS-1]; // reference copy, host view
    addr_t exp_mem_addr  = '0;
    logic  exp_mem_we    = 1'b0;
    word_t exp_mem_wdata = '0;
    int    mstate, mdelay, busy_left;
    logic [MEM_ADDR_BITS-1:0] midx;

    // posedge monitor counters
    logic  mem_req_q, mem_ack_q, enable_q, last_done;
    int    mem_starts, mem_ends, enable_count, sample_count;
    word_t ref_xy; // last sample the latch should hold

    // host task snapshots
    word_t snap_xy;
    int    snap_samples, ack_samples, ack_mem_ends, ack_enables;
    logic  ack_pending;

    mmio_top #(
        .MEM_ADDR_BITS(MEM_ADDR_BITS)
    ) mmio_top_i (
        .clk(clk), .reset(reset),
        .req(req), .we(we), .address(address), .wdata(wdata), .ack(ack), .rdata(rdata),
        .mem_req(mem_req), .mem_write(mem_write), .mem_address(mem_address),
        .mem_wdata(mem_wdata), .mem_ack(mem_ack), .mem_rdata(mem_rdata),
        .spi_params(spi_params), .spi_command(spi_command), .spi_enable(spi_enable),
        .spi_busy(spi_busy),
        .touch_xy(touch_xy), .touch_done(touch_done), .touch_pending(touch_pending)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // fibonacci lfsr x^16+x^14+x^13+x^11, one step per bit
    function automatic word_t rand_bits(input int n, inout logic [15:0] state);
        word_t r;
        int    i;
        r = '0;
        for (i = 0; i < n; i++) begin
            state = {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
            r     = {r[30:0], state[0]};
        end
        return r;
    endfunction

    // power-up contents, built from the full byte address
    function automatic word_t fill_word(input int i);
        addr_t a;
        a = MEM_BASE + addr_t'(i << 2);
        return {~a[15:0], a[15:0]};
    endfunction

    task automatic report_mismatch(input string name, input word_t exp, input word_t got);
        $display("[ERROR] t=%0t %s expected %h got %h", $time, name, exp, got);
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_failure(input string what);
        $display("t=%0t %s", $time, what);
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t got);
        assert (got == exp) else report_mismatch(name, exp, got);
    endtask

    // one four phase host transaction, starts and ends on a falling edge
    task automatic host_access(input logic w, input addr_t a, input word_t d,
                               output word_t r);
        int n;
        @(negedge clk);
        req     = 1'b1;
        we      = w;
        address = a;
        wdata   = d;
        @(negedge clk); // req seen once, ack cannot be up yet
        snap_xy      = ref_xy;
        snap_samples = sample_count;
        n = 0;
        while (!ack) begin
            @(negedge clk);
            n = n + 1;
            if (n > TIMEOUT) report_failure("host ack never rose");
        end
        r            = rdata;
        ack_pending  = touch_pending;
        ack_samples  = sample_count;
        ack_mem_ends = mem_ends;
        ack_enables  = enable_count;
        req = 1'b0;
        n = 0;
        while (ack) begin
            @(negedge clk);
            n = n + 1;
            if (n > TIMEOUT) report_failure("host ack never fell after req dropped");
        end
    endtask

    // edge counters, sampled where the dut outputs are settled
    always @(posedge clk) begin
        if (reset) begin
            mem_req_q    <= 1'b0;
            mem_ack_q    <= 1'b0;
            enable_q     <= 1'b0;
            last_done    <= 1'b0;
            mem_starts   <= 0;
            mem_ends     <= 0;
            enable_count <= 0;
            sample_count <= 0;
            ref_xy       <= '0;
        end else begin
            mem_req_q <= mem_req;
            mem_ack_q <= mem_ack;
            enable_q  <= spi_enable;
            last_done <= touch_done;
            if (mem_req && !mem_req_q) mem_starts <= mem_starts + 1;
            if (!mem_ack && mem_ack_q) mem_ends <= mem_ends + 1; // memory cycle closed
            if (spi_enable) enable_count <= enable_count + 1;
            assert (!(spi_enable && enable_q))
                else report_failure("spi_enable held high for two cycles");
            if (touch_done) begin
                ref_xy       <= touch_xy;
                sample_count <= sample_count + 1;
            end
        end
    end

    // memory model, random ack delay on both phases
    always @(negedge clk) begin
        if (reset) begin
            mem_ack = 1'b0;
            mstate  = 0;
            mdelay  = 0;
            for (int i = 0; i < MEM_WORDS; i++) mem_array[i] = fill_word(i);
        end else begin
            case (mstate)
                0: if (mem_req) begin
                    check_word("mem_address", exp_mem_addr, mem_address);
                    check_word("mem_write", word_t'(exp_mem_we), word_t'(mem_write));
                    if (mem_write) check_word("mem_wdata", exp_mem_wdata, mem_wdata);
                    mdelay = int'(rand_bits(3, mem_seed));
                    mstate = 1;
                end
                1: if (mdelay == 0) begin
                    midx = mem_address[MEM_ADDR_BITS+1:2];
                    if (mem_write) mem_array[midx] = mem_wdata;
                    else mem_rdata = mem_array[midx];
                    mem_ack = 1'b1;
                    mstate  = 2;
                end else begin
                    mdelay = mdelay - 1;
                end
                2: if (!mem_req) begin
                    mdelay = int'(rand_bits(2, mem_seed));
                    mstate = 3;
                end
                default: if (mdelay == 0) begin
                    mem_ack = 1'b0;
                    mstate  = 0;
                end else begin
                    mdelay = mdelay - 1;
                end
            endcase
        end
    end

    // spi peripheral, busy for a random count after each enable
    always @(negedge clk) begin
        if (reset) begin
            spi_busy  = 1'b1; // still busy from power-up
            busy_left = 6;
        end else if (spi_enable) begin
            assert (!spi_busy) else report_mismatch("spi_busy", 32'd0, 32'd1);
            busy_left = 1 + int'(rand_bits(3, spi_seed));
            spi_busy  = 1'b1;
        end else if (busy_left > 0) begin
            busy_left = busy_left - 1;
            if (busy_left == 0) spi_busy = 1'b0;
        end
    end

    // i2c reader, about one sample in 16 cycles
    always @(negedge clk) begin
        if (reset) begin
            touch_done = 1'b0;
        end else begin
            if (last_done) begin
                assert (touch_pending) else report_mismatch("touch_pending", 32'd1, 32'd0);
            end
            touch_done = (rand_bits(4, touch_seed) == 0);
            if (touch_done) touch_xy = rand_bits(32, touch_seed);
        end
    end

    initial begin
        word_t r, d, p;
        addr_t a;
        logic  w;
        logic [MEM_ADDR_BITS-1:0] idx;
        int    k, starts0, ends0, enables0;
        req     = 1'b0;
        we      = 1'b0;
        address = '0;
        wdata   = '0;
        reset   = 1'b1;
        for (k = 0; k < MEM_WORDS; k++) exp_mem[k] = fill_word(k);
        repeat (2) @(negedge clk);
        reset <= 1'b0; // models on this edge still see reset high
        check_word("ack", 32'd0, word_t'(ack));
        check_word("mem_req", 32'd0, word_t'(mem_req));
        check_word("spi_enable", 32'd0, word_t'(spi_enable));
        check_word("touch_pending", 32'd0, word_t'(touch_pending));
        check_word("rdata", 32'd0, rdata);

        // memory window, small index range half the time for read after write hits
        for (k = 0; k < 60; k++) begin
            d = rand_bits(1, main_seed);
            if (d[0]) d = rand_bits(4, main_seed);
            else d = rand_bits(MEM_ADDR_BITS, main_seed);
            idx = d[MEM_ADDR_BITS-1:0];
            d   = rand_bits(1, main_seed);
            w   = d[0];
            exp_mem_addr = MEM_BASE + (addr_t'(idx) << 2);
            exp_mem_we   = w;
            a = exp_mem_addr + rand_bits(2, main_seed); // byte lane bits are dropped
            d = rand_bits(32, main_seed);
            exp_mem_wdata = d;
            starts0 = mem_starts;
            ends0   = mem_ends;
            host_access(w, a, d, r);
            check_word("mem_req rises", starts0 + 1, mem_starts);
            check_word("mem_ack releases at ack", ends0 + 1, ack_mem_ends);
            if (w) exp_mem[idx] = d;
            else check_word("rdata", exp_mem[idx], r);
        end

        // spi parameter then command
        for (k = 0; k < 6; k++) begin
            p = rand_bits(32, main_seed);
            d = rand_bits(32, main_seed);
            enables0 = enable_count;
            starts0  = mem_starts;
            host_access(1'b1, SPI_PARAM_ADDR, p, r);
            check_word("spi_enable pulses", enables0, enable_count);
            host_access(1'b1, SPI_CMD_ADDR, d, r);
            check_word("spi_enable pulses at ack", enables0 + 1, ack_enables);
            check_word("spi_params", p, spi_params);
            check_word("spi_command", word_t'(d[7:0]), word_t'(spi_command));
            check_word("mem_req rises", starts0, mem_starts);
        end

        // touch reads with random gaps so samples pile up or race the read
        for (k = 0; k < 12; k++) begin
            d = rand_bits(4, main_seed);
            repeat (d) @(negedge clk);
            host_access(1'b0, TOUCH_ADDR, '0, r);
            check_word("rdata", snap_xy, r);
            check_word("touch_pending", word_t'(ack_samples != snap_samples),
                       word_t'(ack_pending));
        end

        // unmapped reads and touch writes
        for (k = 0; k < 12; k++) begin
            d = rand_bits(2, main_seed);
            w = 1'b0;
            case (d[1:0])
                2'd0: a = rand_bits(8, main_seed); // below the register block
                2'd1: a = SPI_PARAM_ADDR;          // write only
                2'd2: a = MEM_BASE + 32'h0001_0000 + rand_bits(12, main_seed);
                default: begin
                    a = TOUCH_ADDR;
                    w = 1'b1;
                end
            endcase
            starts0  = mem_starts;
            enables0 = enable_count;
            host_access(w, a, rand_bits(32, main_seed), r);
            check_word("rdata", 32'd0, r);
            check_word("mem_req rises", starts0, mem_starts);
            check_word("spi_enable pulses", enables0, enable_count);
        end

        $display("Test OK");
        $finish;
    end

endmodule
